// File: ooo_core.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/inst_decoder.sv
rtl/rename_unit.sv
rtl/phys_reg_file.sv
rtl/reservation_station.sv
rtl/alu_stage.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
testbench/ooo_core_tb.sv

// File: rtl/alu_stage.sv
module alu_stage #(
    parameter int  NUM_PHYS  = core_pkg::DEF_NUM_PHYS,
    parameter int  ROB_DEPTH = core_pkg::DEF_ROB_DEPTH,
    localparam int TAG_W     = $clog2(NUM_PHYS),
    localparam int ROB_W     = $clog2(ROB_DEPTH)
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue_valid,
    input  isa_pkg::alu_op_e         issue_op,
    input  logic [isa_pkg::XLEN-1:0] issue_a,
    input  logic [isa_pkg::XLEN-1:0] issue_b,
    input  logic [TAG_W-1:0]         issue_tag,
    input  logic [ROB_W-1:0]         issue_rob_idx,
    output logic                     wb_valid,
    output logic [TAG_W-1:0]         wb_tag,
    output logic [ROB_W-1:0]         wb_rob_idx,
    output logic [isa_pkg::XLEN-1:0] wb_value
);
    import isa_pkg::*;

    logic [XLEN-1:0] result;
    logic [4:0]      shamt;

    assign shamt = issue_b[4:0];

    always_comb begin
        case (issue_op)
            ALU_SUB:    result = issue_a - issue_b;
            ALU_SLL:    result = issue_a << shamt;
            ALU_SLT:    result = XLEN'($signed(issue_a) < $signed(issue_b));
            ALU_SLTU:   result = XLEN'(issue_a < issue_b);
            ALU_XOR:    result = issue_a ^ issue_b;
            ALU_SRL:    result = issue_a >> shamt;
            ALU_SRA:    result = XLEN'($signed(issue_a) >>> shamt);
            ALU_OR:     result = issue_a | issue_b;
            ALU_AND:    result = issue_a & issue_b;
            ALU_PASS_B: result = issue_b;
            default:    result = issue_a + issue_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= issue_valid;   // one pulse per issued op
    end

    always_ff @(posedge clk) begin
        wb_tag     <= issue_tag;
        wb_rob_idx <= issue_rob_idx;
        wb_value   <= result;
    end

endmodule

// File: rtl/core_pkg.sv
package core_pkg;

    localparam int NUM_LOGICAL = 32;

    // sizes used by ooo_core unless overridden
    localparam int DEF_NUM_PHYS  = 64;
    localparam int DEF_ROB_DEPTH = 8;
    localparam int DEF_RS_DEPTH  = 4;

endpackage

// File: rtl/inst_decoder.sv
module inst_decoder (
    input  logic [isa_pkg::XLEN-1:0]       inst,
    output logic [isa_pkg::REG_ADDR_W-1:0] rs1,
    output logic [isa_pkg::REG_ADDR_W-1:0] rs2,
    output logic [isa_pkg::REG_ADDR_W-1:0] rd,
    output logic                           use_imm,
    output logic [isa_pkg::XLEN-1:0]       imm,
    output isa_pkg::alu_op_e               alu_op
);
    import isa_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;    // funct7[5], sub and sra

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign alt    = inst[30];
    assign rd     = inst[11:7];

    always_comb begin
        rs1     = inst[19:15];
        rs2     = inst[24:20];
        use_imm = 1'b0;
        imm     = {{20{inst[31]}}, inst[31:20]};
        case (funct3)
            3'b000:  alu_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        case (opcode)
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                rs2     = '0;   // x0 is always ready
            end
            OPC_LUI: begin
                use_imm = 1'b1;
                rs1     = '0;
                rs2     = '0;
                imm     = {inst[31:12], 12'b0};
                alu_op  = ALU_PASS_B;
            end
            default: ;  // register form
        endcase
    end

endmodule

// File: rtl/isa_pkg.sv
package isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes that the core decodes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // lui
    } alu_op_e;

endpackage

// File: rtl/ooo_core.sv
module ooo_core #(
    parameter int NUM_PHYS  = core_pkg::DEF_NUM_PHYS,
    parameter int ROB_DEPTH = core_pkg::DEF_ROB_DEPTH,
    parameter int RS_DEPTH  = core_pkg::DEF_RS_DEPTH
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           inst_valid,
    input  logic [isa_pkg::XLEN-1:0]       inst,
    output logic                           stall,
    output logic                           commit_valid,
    output logic [isa_pkg::REG_ADDR_W-1:0] commit_rd,
    output logic [isa_pkg::XLEN-1:0]       commit_value
);
    import isa_pkg::*;

    localparam int TAG_W = $clog2(NUM_PHYS);
    localparam int ROB_W = $clog2(ROB_DEPTH);

    logic                  accept;
    logic [TAG_W-1:0]      src1_tag, src2_tag, dst_tag, old_tag;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       src1_data, src2_data;
    logic                  src1_ready, src2_ready;
    logic                  rob_full, rs_full;
    logic [ROB_W-1:0]      tail_idx;
    logic                  issue_valid;
    alu_op_e               issue_op;
    logic [XLEN-1:0]       issue_a, issue_b;
    logic [TAG_W-1:0]      issue_tag;
    logic [ROB_W-1:0]      issue_rob_idx;
    logic                  wb_valid;
    logic [TAG_W-1:0]      wb_tag;
    logic [ROB_W-1:0]      wb_rob_idx;
    logic [XLEN-1:0]       wb_value;
    logic                  free_valid;
    logic [TAG_W-1:0]      free_tag;

    assign accept = inst_valid & ~stall;

    rename_unit #(.NUM_PHYS(NUM_PHYS)) u_rename (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
        .rob_full(rob_full), .rs_full(rs_full),
        .free_valid(free_valid), .free_tag(free_tag),
        .src1_tag(src1_tag), .src2_tag(src2_tag), .dst_tag(dst_tag), .old_tag(old_tag),
        .stall(stall), .rd(rd), .imm(imm), .use_imm(use_imm), .alu_op(alu_op)
    );

    phys_reg_file #(.NUM_PHYS(NUM_PHYS)) u_prf (
        .clk(clk), .rst_n(rst_n), .rd_tag1(src1_tag), .rd_tag2(src2_tag),
        .alloc_valid(accept), .alloc_tag(dst_tag),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value),
        .rd_data1(src1_data), .rd_data2(src2_data),
        .rd_ready1(src1_ready), .rd_ready2(src2_ready)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH), .NUM_PHYS(NUM_PHYS), .ROB_DEPTH(ROB_DEPTH)) u_rs (
        .clk(clk), .rst_n(rst_n), .disp_valid(accept), .alu_op(alu_op),
        .use_imm(use_imm), .imm(imm), .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_data(src1_data), .src2_data(src2_data),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .dst_tag(dst_tag), .rob_idx(tail_idx),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value), .rs_full(rs_full),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b),
        .issue_tag(issue_tag), .issue_rob_idx(issue_rob_idx)
    );

    alu_stage #(.NUM_PHYS(NUM_PHYS), .ROB_DEPTH(ROB_DEPTH)) u_alu (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag),
        .issue_rob_idx(issue_rob_idx), .wb_valid(wb_valid), .wb_tag(wb_tag),
        .wb_rob_idx(wb_rob_idx), .wb_value(wb_value)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH), .NUM_PHYS(NUM_PHYS)) u_rob (
        .clk(clk), .rst_n(rst_n), .alloc_valid(accept), .alloc_rd(rd),
        .alloc_old_tag(old_tag), .wb_valid(wb_valid), .wb_rob_idx(wb_rob_idx),
        .wb_value(wb_value), .rob_full(rob_full), .tail_idx(tail_idx),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value),
        .free_valid(free_valid), .free_tag(free_tag)
    );

endmodule

// File: rtl/phys_reg_file.sv
module phys_reg_file #(
    parameter int  NUM_PHYS = core_pkg::DEF_NUM_PHYS,
    localparam int TAG_W    = $clog2(NUM_PHYS)
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [TAG_W-1:0]         rd_tag1,
    input  logic [TAG_W-1:0]         rd_tag2,
    input  logic                     alloc_valid,
    input  logic [TAG_W-1:0]         alloc_tag,
    input  logic                     wb_valid,
    input  logic [TAG_W-1:0]         wb_tag,
    input  logic [isa_pkg::XLEN-1:0] wb_value,
    output logic [isa_pkg::XLEN-1:0] rd_data1,
    output logic [isa_pkg::XLEN-1:0] rd_data2,
    output logic                     rd_ready1,
    output logic                     rd_ready2
);
    import isa_pkg::*;

    logic [XLEN-1:0]     regs [NUM_PHYS];
    logic [NUM_PHYS-1:0] ready;

    assign rd_data1  = regs[rd_tag1];
    assign rd_data2  = regs[rd_tag2];
    assign rd_ready1 = ready[rd_tag1];
    assign rd_ready2 = ready[rd_tag2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PHYS; i++)
                regs[i] <= '0;
            ready <= '1;
        end else begin
            if (alloc_valid && alloc_tag != '0)
                ready[alloc_tag] <= 1'b0;   // pending until its result comes back
            if (wb_valid && wb_tag != '0) begin   // tag 0 stays zero
                regs[wb_tag]  <= wb_value;
                ready[wb_tag] <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/rename_unit.sv
module rename_unit #(
    parameter int   NUM_PHYS = core_pkg::DEF_NUM_PHYS,
    localparam int  TAG_W    = $clog2(NUM_PHYS)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           inst_valid,
    input  logic [isa_pkg::XLEN-1:0]       inst,
    input  logic                           rob_full,
    input  logic                           rs_full,
    input  logic                           free_valid,
    input  logic [TAG_W-1:0]               free_tag,
    output logic [TAG_W-1:0]               src1_tag,
    output logic [TAG_W-1:0]               src2_tag,
    output logic [TAG_W-1:0]               dst_tag,
    output logic [TAG_W-1:0]               old_tag,
    output logic                           stall,
    output logic [isa_pkg::REG_ADDR_W-1:0] rd,
    output logic [isa_pkg::XLEN-1:0]       imm,
    output logic                           use_imm,
    output isa_pkg::alu_op_e               alu_op
);
    import isa_pkg::*;
    import core_pkg::*;

    localparam int FL_DEPTH = NUM_PHYS - NUM_LOGICAL;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);

    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [TAG_W-1:0]      rat [NUM_LOGICAL];
    logic [TAG_W-1:0]      fl_mem [FL_DEPTH];
    logic [FL_PTR_W-1:0]   fl_head;
    logic [FL_PTR_W-1:0]   fl_tail;
    logic [FL_PTR_W:0]     fl_count;
    logic                  take;

    inst_decoder u_dec (
        .inst    (inst),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .use_imm (use_imm),
        .imm     (imm),
        .alu_op  (alu_op)
    );

    assign stall    = (fl_count == '0) | rob_full | rs_full;
    assign take     = inst_valid & ~stall & (rd != '0);   // x0 keeps tag 0
    assign src1_tag = rat[rs1];   // old mapping, before this edge
    assign src2_tag = rat[rs2];
    assign old_tag  = rat[rd];
    assign dst_tag  = (rd == '0) ? '0 : fl_mem[fl_head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_LOGICAL; i++)
                rat[i] <= TAG_W'(i);
            for (int i = 0; i < FL_DEPTH; i++)
                fl_mem[i] <= TAG_W'(NUM_LOGICAL + i);
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (FL_PTR_W+1)'(FL_DEPTH);
        end else begin
            if (take) begin
                rat[rd] <= fl_mem[fl_head];
                fl_head <= (fl_head == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : fl_head + 1'b1;
            end
            if (free_valid) begin
                fl_mem[fl_tail] <= free_tag;
                fl_tail <= (fl_tail == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : fl_tail + 1'b1;
            end
            fl_count <= fl_count + (FL_PTR_W+1)'(free_valid) - (FL_PTR_W+1)'(take);
        end
    end

    // the ROB hands back a tag only while one is out
    a_fl_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        free_valid |-> fl_count != (FL_PTR_W+1)'(FL_DEPTH));

endmodule

// File: rtl/reorder_buffer.sv
module reorder_buffer #(
    parameter int  ROB_DEPTH = core_pkg::DEF_ROB_DEPTH,
    parameter int  NUM_PHYS  = core_pkg::DEF_NUM_PHYS,
    localparam int TAG_W     = $clog2(NUM_PHYS),
    localparam int IDX_W     = $clog2(ROB_DEPTH)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           alloc_valid,
    input  logic [isa_pkg::REG_ADDR_W-1:0] alloc_rd,
    input  logic [TAG_W-1:0]               alloc_old_tag,
    input  logic                           wb_valid,
    input  logic [IDX_W-1:0]               wb_rob_idx,
    input  logic [isa_pkg::XLEN-1:0]       wb_value,
    output logic                           rob_full,
    output logic [IDX_W-1:0]               tail_idx,
    output logic                           commit_valid,
    output logic [isa_pkg::REG_ADDR_W-1:0] commit_rd,
    output logic [isa_pkg::XLEN-1:0]       commit_value,
    output logic                           free_valid,
    output logic [TAG_W-1:0]               free_tag
);
    import isa_pkg::*;

    logic [REG_ADDR_W-1:0] ent_rd  [ROB_DEPTH];
    logic [TAG_W-1:0]      ent_old [ROB_DEPTH];
    logic [XLEN-1:0]       ent_val [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]  ent_done;
    logic [IDX_W-1:0]      head;
    logic [IDX_W-1:0]      tail;
    logic [IDX_W:0]        count;
    logic                  retire;

    assign rob_full = count == (IDX_W+1)'(ROB_DEPTH);
    assign tail_idx = tail;
    assign retire   = (count != '0) && ent_done[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ent_done     <= '0;
            commit_valid <= 1'b0;
            free_valid   <= 1'b0;
        end else begin
            if (alloc_valid) begin
                ent_done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (wb_valid)
                ent_done[wb_rob_idx] <= 1'b1;
            if (retire)
                head <= head + 1'b1;
            count        <= count + (IDX_W+1)'(alloc_valid) - (IDX_W+1)'(retire);
            commit_valid <= retire;
            free_valid   <= retire && ent_rd[head] != '0;   // x0 owns no tag
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            ent_rd[tail]  <= alloc_rd;
            ent_old[tail] <= alloc_old_tag;
        end
        if (wb_valid)
            ent_val[wb_rob_idx] <= wb_value;
        commit_rd    <= ent_rd[head];
        commit_value <= ent_val[head];
        free_tag     <= ent_old[head];
    end

    // head and tail only meet on a retire when the buffer is full
    a_no_empty_commit: assert property (@(posedge clk) disable iff (!rst_n)
        retire |-> (head != tail || rob_full));

endmodule

// File: rtl/reservation_station.sv
module reservation_station #(
    parameter int  RS_DEPTH  = core_pkg::DEF_RS_DEPTH,
    parameter int  NUM_PHYS  = core_pkg::DEF_NUM_PHYS,
    parameter int  ROB_DEPTH = core_pkg::DEF_ROB_DEPTH,
    localparam int TAG_W     = $clog2(NUM_PHYS),
    localparam int ROB_W     = $clog2(ROB_DEPTH)
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     disp_valid,
    input  isa_pkg::alu_op_e         alu_op,
    input  logic                     use_imm,
    input  logic [isa_pkg::XLEN-1:0] imm,
    input  logic [TAG_W-1:0]         src1_tag,
    input  logic [TAG_W-1:0]         src2_tag,
    input  logic [isa_pkg::XLEN-1:0] src1_data,
    input  logic [isa_pkg::XLEN-1:0] src2_data,
    input  logic                     src1_ready,
    input  logic                     src2_ready,
    input  logic [TAG_W-1:0]         dst_tag,
    input  logic [ROB_W-1:0]         rob_idx,
    input  logic                     wb_valid,
    input  logic [TAG_W-1:0]         wb_tag,
    input  logic [isa_pkg::XLEN-1:0] wb_value,
    output logic                     rs_full,
    output logic                     issue_valid,
    output isa_pkg::alu_op_e         issue_op,
    output logic [isa_pkg::XLEN-1:0] issue_a,
    output logic [isa_pkg::XLEN-1:0] issue_b,
    output logic [TAG_W-1:0]         issue_tag,
    output logic [ROB_W-1:0]         issue_rob_idx
);
    import isa_pkg::*;

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0] ent_valid;
    logic [RS_DEPTH-1:0] rdy1;
    logic [RS_DEPTH-1:0] rdy2;
    logic [RS_DEPTH-1:0] ent_imm_sel;
    alu_op_e             ent_op   [RS_DEPTH];
    logic [XLEN-1:0]     ent_imm  [RS_DEPTH];
    logic [TAG_W-1:0]    tag1     [RS_DEPTH];
    logic [TAG_W-1:0]    tag2     [RS_DEPTH];
    logic [XLEN-1:0]     val1     [RS_DEPTH];
    logic [XLEN-1:0]     val2     [RS_DEPTH];
    logic [TAG_W-1:0]    ent_dst  [RS_DEPTH];
    logic [ROB_W-1:0]    ent_rob  [RS_DEPTH];
    logic [IDX_W-1:0]    issue_sel;
    logic [IDX_W-1:0]    free_sel;
    logic                byp1;
    logic                byp2;

    // bypass for a result broadcast in the dispatch cycle
    // tag 0 is always ready so it never takes the bypass
    assign byp1    = wb_valid && !src1_ready && wb_tag == src1_tag;
    assign byp2    = wb_valid && !src2_ready && wb_tag == src2_tag;
    assign rs_full = &ent_valid;

    always_comb begin
        issue_valid = 1'b0;
        issue_sel   = '0;
        free_sel    = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin   // lowest index wins
            if (ent_valid[i] && rdy1[i] && rdy2[i]) begin
                issue_valid = 1'b1;
                issue_sel   = IDX_W'(i);
            end
            if (!ent_valid[i])
                free_sel = IDX_W'(i);
        end
    end

    assign issue_op      = ent_op[issue_sel];
    assign issue_a       = val1[issue_sel];
    assign issue_b       = ent_imm_sel[issue_sel] ? ent_imm[issue_sel] : val2[issue_sel];
    assign issue_tag     = ent_dst[issue_sel];
    assign issue_rob_idx = ent_rob[issue_sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin   // wakeup
                if (ent_valid[i] && wb_valid && !rdy1[i] && tag1[i] == wb_tag) begin
                    rdy1[i] <= 1'b1;
                    val1[i] <= wb_value;
                end
                if (ent_valid[i] && wb_valid && !rdy2[i] && tag2[i] == wb_tag) begin
                    rdy2[i] <= 1'b1;
                    val2[i] <= wb_value;
                end
            end
            if (issue_valid)
                ent_valid[issue_sel] <= 1'b0;
            if (disp_valid) begin
                ent_valid[free_sel]   <= 1'b1;
                ent_op[free_sel]      <= alu_op;
                ent_imm_sel[free_sel] <= use_imm;
                ent_imm[free_sel]     <= imm;
                tag1[free_sel]        <= src1_tag;
                tag2[free_sel]        <= src2_tag;
                rdy1[free_sel]        <= src1_ready | byp1;
                rdy2[free_sel]        <= src2_ready | byp2;
                val1[free_sel]        <= byp1 ? wb_value : src1_data;
                val2[free_sel]        <= byp2 ? wb_value : src2_data;
                ent_dst[free_sel]     <= dst_tag;
                ent_rob[free_sel]     <= rob_idx;
            end
        end
    end

    // an issued operand's result is never still on its way
    a_issue_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_valid && wb_valid && wb_tag != '0) |->
            (wb_tag != tag1[issue_sel] && wb_tag != tag2[issue_sel]));

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Mdir obj_dir --top-module ooo_core_tb -f ooo_core.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vooo_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
    exit 0
fi
exit 1

// File: testbench/ooo_core_tb.sv
module ooo_core_tb;
    import isa_pkg::*;

    localparam int RESET_CYCLES    = 8;
    localparam int N_SEED          = 62;
    localparam int N_FORMS         = 40;
    localparam int N_CHAIN         = 24;
    localparam int N_STREAM        = 200;
    localparam int N_BURST         = 24;
    localparam int N_ZERO          = 4;
    localparam int N_TOTAL         = N_SEED + N_FORMS + N_CHAIN + N_STREAM + N_BURST + N_ZERO;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * N_TOTAL;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_valid;
    logic [XLEN-1:0]       inst;
    logic                  stall;
    logic                  commit_valid;
    logic [REG_ADDR_W-1:0] commit_rd;
    logic [XLEN-1:0]       commit_value;

    logic [XLEN-1:0]       arch_regs [32];   // architectural state in program order
    logic [REG_ADDR_W-1:0] exp_rd_q  [$];
    logic [XLEN-1:0]       exp_val_q [$];
    logic [31:0]           rng_state;
    logic                  saw_stall;
    int                    sent_count;
    int                    commit_count;
    int                    check_count;
    int                    errors;
    int                    test_errors_base;

    ooo_core #(
        .NUM_PHYS  (core_pkg::DEF_NUM_PHYS),
        .ROB_DEPTH (core_pkg::DEF_ROB_DEPTH),
        .RS_DEPTH  (core_pkg::DEF_RS_DEPTH)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .stall        (stall),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((next_rand() >> 16) % 32'(n));   // upper lcg bits
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(1 + rand_below(31));
    endfunction

    // kinds 0..9 register form, 10..18 immediate form, 19 lui
    function automatic logic [31:0] make_op(input int kind, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [31:0] r);
        logic [11:0] imm;
        imm = r[11:0];
        case (kind)
            0:       return {7'h00, rs2, rs1, 3'b000, rd, OPC_OP};
            1:       return {7'h20, rs2, rs1, 3'b000, rd, OPC_OP};   // sub
            2:       return {7'h00, rs2, rs1, 3'b001, rd, OPC_OP};
            3:       return {7'h00, rs2, rs1, 3'b010, rd, OPC_OP};
            4:       return {7'h00, rs2, rs1, 3'b011, rd, OPC_OP};
            5:       return {7'h00, rs2, rs1, 3'b100, rd, OPC_OP};
            6:       return {7'h00, rs2, rs1, 3'b101, rd, OPC_OP};
            7:       return {7'h20, rs2, rs1, 3'b101, rd, OPC_OP};   // sra
            8:       return {7'h00, rs2, rs1, 3'b110, rd, OPC_OP};
            9:       return {7'h00, rs2, rs1, 3'b111, rd, OPC_OP};
            10:      return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
            11:      return {imm, rs1, 3'b010, rd, OPC_OP_IMM};
            12:      return {imm, rs1, 3'b011, rd, OPC_OP_IMM};
            13:      return {imm, rs1, 3'b100, rd, OPC_OP_IMM};
            14:      return {imm, rs1, 3'b110, rd, OPC_OP_IMM};
            15:      return {imm, rs1, 3'b111, rd, OPC_OP_IMM};
            16:      return {7'h00, imm[4:0], rs1, 3'b001, rd, OPC_OP_IMM};
            17:      return {7'h00, imm[4:0], rs1, 3'b101, rd, OPC_OP_IMM};
            18:      return {7'h20, imm[4:0], rs1, 3'b101, rd, OPC_OP_IMM};   // srai
            default: return {r[31:12], rd, OPC_LUI};
        endcase
    endfunction

    function automatic logic [31:0] ref_result(input logic [31:0] ins);
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] sa;
        logic [4:0]         sh;
        logic               is_reg;
        if (ins[6:0] == OPC_LUI)
            return {ins[31:12], 12'b0};
        is_reg = ins[6:0] == OPC_OP;
        a      = arch_regs[ins[19:15]];
        b      = is_reg ? arch_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        sa     = a;
        sh     = b[4:0];
        case (ins[14:12])
            3'b000:  return (is_reg && ins[30]) ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (ins[30])
                    return sa >>> sh;
                return a >> sh;
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // entered just after a rising edge, returns just after the accepting one
    task automatic send_inst(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [31:0] value;
        inst_valid <= 1'b1;
        inst       <= ins;
        @(negedge clk);
        while (stall) begin
            saw_stall = 1'b1;
            @(negedge clk);
        end
        rd    = ins[11:7];
        value = ref_result(ins);
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(value);
        if (rd != 5'd0)
            arch_regs[rd] = value;   // x0 stays zero
        sent_count++;
        @(posedge clk);
    endtask

    task automatic drain();
        inst_valid <= 1'b0;
        while (exp_rd_q.size() != 0)
            @(posedge clk);
        @(posedge clk);
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s done, %0d errors", num, name, errors - test_errors_base);
        test_errors_base = errors;
    endtask

    always @(negedge clk) begin
        logic [4:0]  exp_rd;
        logic [31:0] exp_val;
        if (rst_n && commit_valid) begin
            commit_count++;
            if (exp_rd_q.size() == 0) begin
                errors++;
                $display("commit of x%0d seen with no instruction outstanding", commit_rd);
            end else begin
                exp_rd  = exp_rd_q.pop_front();
                exp_val = exp_val_q.pop_front();
                check_equal("commit_rd", 32'(commit_rd), 32'(exp_rd));
                check_equal("commit_value", commit_value, exp_val);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, commits stopped before the queue drained",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n            = 1'b0;
        inst_valid       = 1'b0;
        inst             = '0;
        rng_state        = 32'h1608_0c79;
        saw_stall        = 1'b0;
        sent_count       = 0;
        commit_count     = 0;
        check_count      = 0;
        errors           = 0;
        test_errors_base = 0;
        for (int i = 0; i < 32; i++)
            arch_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_equal("commit_valid", 32'(commit_valid), 32'd0);
        check_equal("stall", 32'(stall), 32'd0);
        end_test(1, "reset state");
        @(posedge clk);

        for (int r = 1; r < 32; r++) begin   // lui then addi gives a full random value
            send_inst(make_op(19, 5'(r), 5'd0, 5'd0, next_rand()));
            send_inst(make_op(10, 5'(r), 5'(r), 5'd0, next_rand()));
        end
        for (int k = 0; k < N_FORMS; k++)
            send_inst(make_op(k % 20, rand_reg(), rand_reg(), rand_reg(), next_rand()));
        drain();
        end_test(2, "all forms");

        for (int k = 0; k < N_CHAIN / 2; k++)
            send_inst(make_op(rand_below(19), 5'd5, 5'd5, 5'd5, next_rand()));
        for (int k = 0; k < N_CHAIN / 2; k++)
            send_inst(make_op(rand_below(19), 5'(7 + (k + 1) % 4), 5'(7 + k % 4), 5'd5,
                              next_rand()));
        drain();
        end_test(3, "dependent chains");

        for (int k = 0; k < N_STREAM; k++)
            send_inst(make_op(rand_below(20), 5'(rand_below(32)), 5'(rand_below(32)),
                              5'(rand_below(32)), next_rand()));
        drain();
        check_equal("commit_count", 32'(commit_count), 32'(sent_count));
        end_test(4, "random stream");

        saw_stall = 1'b0;
        for (int k = 0; k < N_BURST; k++)   // serial chain issues slower than dispatch
            send_inst(make_op(10, 5'd9, 5'd9, 5'd0, next_rand()));
        drain();
        check_equal("saw_stall", 32'(saw_stall), 32'd1);
        @(negedge clk);
        check_equal("stall", 32'(stall), 32'd0);
        check_equal("commit_count", 32'(commit_count), 32'(sent_count));
        end_test(5, "burst with stall");
        @(posedge clk);

        send_inst(make_op(10, 5'd0, 5'd3, 5'd0, 32'h155));
        send_inst(make_op(0, 5'd11, 5'd0, 5'd3, 32'd0));
        send_inst(make_op(14, 5'd12, 5'd0, 5'd0, 32'h7ff));
        send_inst(make_op(1, 5'd13, 5'd3, 5'd0, 32'd0));
        drain();
        end_test(6, "x0 handling");

        $display("checks %0d, errors %0d, sent %0d, committed %0d",
                 check_count, errors, sent_count, commit_count);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
